// ==== instr_queue.f ====
design/iq_pkg.sv
design/fetch_sequencer.sv
design/iq_storage.sv
design/commit_unit.sv
design/instr_queue.sv
sim/iq_checker.sv
sim/tb_instr_queue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_instr_queue
RTL_TOP   ?= instr_queue
FILELIST  ?= instr_queue.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) design/iq_pkg.sv design/fetch_sequencer.sv \
		design/iq_storage.sv design/commit_unit.sv design/instr_queue.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_instr_queue.sv ====
module tb_instr_queue;
  timeunit 1ns;
  timeprecision 100ps;
  import iq_pkg::*;

  localparam int IQ_DEPTH = 16;
  localparam int IDX_W    = $clog2(IQ_DEPTH);
  localparam int PROG_LEN = 27;

  logic clk, rst;
  logic fetch_req, fetch_valid, decode_req, decode_valid, pc_write;
  word_t fetch_instr, decode_instr, wb_result;
  addr_t fetch_pc, pc_write_val, wb_tar_addr, clear_pc;
  decoded_t decoded;
  logic wb_valid, store_done, reg_commit_valid, store_valid, clear_valid;
  logic [IDX_W-1:0] wb_idx;
  reg_commit_t reg_commit;
  store_req_t store;
  int exp_cnt, seen_cnt, err_cnt;
  logic done;

  // program row: {decoded_t, result, tar_addr}
  logic [106:0] prog [PROG_LEN];
  logic [31:0] lfsr;
  int pend_idx [$];
  addr_t pend_pc [$];
  addr_t cur_pc, dec_pc;
  int fetch_wait, dec_wait, st_wait, alloc_cnt;

  instr_queue #(.IQ_DEPTH(IQ_DEPTH)) uut (.*);

  iq_checker #(.IQ_DEPTH(IQ_DEPTH), .PROG_LEN(PROG_LEN)) chk (
    .clk(clk), .rst(rst), .prog(prog),
    .fetch_valid(fetch_valid), .fetch_instr(fetch_instr),
    .decode_req(decode_req), .decode_instr(decode_instr),
    .wb_valid(wb_valid), .store_done(store_done),
    .reg_commit_valid(reg_commit_valid), .reg_commit(reg_commit),
    .store_valid(store_valid), .store(store), .clear_valid(clear_valid),
    .clear_pc(clear_pc), .exp_cnt(exp_cnt), .seen_cnt(seen_cnt),
    .err_cnt(err_cnt), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task set_row(input int i, input opcode_e op, input int rd, input int f3,
               input word_t imm, input word_t res, input addr_t tar);
    prog[i] = {op, 5'(rd), 3'(f3), imm, res, tar};
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic logic [106:0] row_at(addr_t pc);
    if (int'(pc >> 2) < PROG_LEN) return prog[int'(pc >> 2)];
    return '0;
  endfunction

  task drive_cycle();
    int r;
    int j;
    logic [106:0] row;
    fetch_valid  = 1'b0;
    decode_valid = 1'b0;
    wb_valid     = 1'b0;
    store_done   = 1'b0;
    if (st_wait > 0) begin
      st_wait--;
      if (st_wait == 0) store_done = 1'b1;
    end
    if (store_valid) begin
      r = take_bits(2);
      st_wait = r + 1;
    end
    if (clear_valid) begin
      // wrong path responses are abandoned
      pend_idx.delete();
      pend_pc.delete();
      fetch_wait = 0;
      dec_wait   = 0;
      alloc_cnt  = 0;
      cur_pc     = clear_pc;
    end else begin
      if (pc_write) cur_pc = pc_write_val;
      r = take_bits(3);
      // hold writebacks back so the queue fills up now and then
      if (pend_idx.size() > 0 && (pend_idx.size() >= IQ_DEPTH - 2 || r == 0)) begin
        r = take_bits(4);
        j = r % pend_idx.size();
        row = row_at(pend_pc[j]);
        wb_valid    = 1'b1;
        wb_idx      = IDX_W'(pend_idx[j]);
        wb_result   = row[63:32];
        wb_tar_addr = row[31:0];
        pend_idx.delete(j);
        pend_pc.delete(j);
      end
      if (fetch_wait > 0) begin
        fetch_wait--;
        if (fetch_wait == 0) begin
          fetch_valid = 1'b1;
          fetch_pc    = cur_pc;
          // low bits set as in a 32-bit encoding
          fetch_instr = cur_pc | 32'h3;
          dec_pc      = cur_pc;
        end
      end
      if (fetch_req) begin
        r = take_bits(2);
        fetch_wait = 1 + r % 3;
      end
      if (dec_wait > 0) begin
        dec_wait--;
        if (dec_wait == 0) begin
          row = row_at(dec_pc);
          decode_valid = 1'b1;
          decoded      = decoded_t'(row[106:64]);
          pend_idx.push_back(alloc_cnt);
          pend_pc.push_back(dec_pc);
          alloc_cnt = (alloc_cnt + 1) % IQ_DEPTH;
        end
      end
      if (decode_req) begin
        r = take_bits(1);
        dec_wait = 1 + r;
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    fetch_pc = '0;
    decode_valid = 1'b0;
    decoded = '0;
    wb_valid = 1'b0;
    wb_idx = '0;
    wb_result = '0;
    wb_tar_addr = '0;
    store_done = 1'b0;
    lfsr = 32'h1fc7;
    cur_pc = '0;
    dec_pc = '0;
    fetch_wait = 0;
    dec_wait = 0;
    st_wait = 0;
    alloc_cnt = 0;
    set_row(0, opc_op, 1, 0, 0, 32'h11, 0);
    set_row(1, opc_op, 2, 0, 0, 32'h22, 0);
    set_row(2, opc_store, 0, 2, 0, 32'hdeadbeef, 32'h100);
    set_row(3, opc_op, 0, 0, 0, 32'h5, 0);
    set_row(4, opc_branch, 0, 0, 8, 32'h1, 0);
    set_row(5, opc_op, 3, 0, 0, 32'h33, 0);
    set_row(6, opc_store, 0, 0, 0, 32'hab, 32'h104);
    set_row(7, opc_branch, 0, 1, 16, 32'h0, 0);
    set_row(8, opc_op, 4, 0, 0, 32'h44, 0);
    set_row(9, opc_jal, 5, 0, 12, 32'd40, 0);
    set_row(10, opc_op, 6, 0, 0, 32'h66, 0);
    set_row(11, opc_op, 7, 0, 0, 32'h77, 0);
    set_row(12, opc_store, 0, 1, 0, 32'h1234, 32'h108);
    set_row(13, opc_jalr, 8, 0, 0, 32'd56, 32'd64);
    set_row(14, opc_op, 9, 0, 0, 32'h99, 0);
    set_row(15, opc_op, 10, 0, 0, 32'haa, 0);
    for (int i = 16; i < 26; i++) begin
      set_row(i, opc_op, i - 5, 0, 0, 32'h100 + 32'(i), 0);
    end
    // jal to itself keeps fetch busy once the trace is done
    set_row(26, opc_jal, 0, 0, 0, 32'd108, 0);
    repeat (3) @(posedge clk);
    #5 rst = 1'b0;
    forever begin
      @(posedge clk);
      #5;
      drive_cycle();
    end
  end

  initial begin
    wait (done);
    repeat (30) @(posedge clk);
    $display("errors: %0d, commits checked: %0d of %0d", err_cnt, seen_cnt, exp_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #2;
    repeat (3 + 200 * exp_cnt) @(posedge clk);
    $display("timeout: only %0d of %0d commits seen, errors: %0d", seen_cnt, exp_cnt, err_cnt);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== sim/iq_checker.sv ====
module iq_checker #(
  parameter int IQ_DEPTH = 16,
  parameter int PROG_LEN = 27
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [106:0]        prog [PROG_LEN],
  input  logic                fetch_valid,
  input  iq_pkg::word_t       fetch_instr,
  input  logic                decode_req,
  input  iq_pkg::word_t       decode_instr,
  input  logic                wb_valid,
  input  logic                store_done,
  input  logic                reg_commit_valid,
  input  iq_pkg::reg_commit_t reg_commit,
  input  logic                store_valid,
  input  iq_pkg::store_req_t  store,
  input  logic                clear_valid,
  input  iq_pkg::addr_t       clear_pc,
  output int                  exp_cnt,
  output int                  seen_cnt,
  output int                  err_cnt,
  output logic                done
);
  timeunit 1ns;
  timeprecision 100ps;
  import iq_pkg::*;

  // one row per commit cycle: kind bits are {reg, store, clear}
  logic [2:0] exp_kind [64];
  logic [31:0] exp_rd [64];
  logic [31:0] exp_ren [64];
  logic [31:0] exp_val [64];
  logic [31:0] exp_addr [64];
  logic [31:0] exp_len [64];
  logic [31:0] exp_cpc [64];
  logic        storing;
  logic        seen_wb;
  word_t       last_instr;

  task check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("Error: %s expected %h got %h at %0t", name, exp, got, $time);
      err_cnt++;
    end
  endtask

  // architectural walk of the program from pc 0
  initial begin
    decoded_t d;
    word_t    res;
    addr_t    tar;
    addr_t    pc;
    int       idx;
    int       k;
    logic     rc;
    logic     st;
    logic     cl;
    exp_cnt    = 0;
    seen_cnt   = 0;
    err_cnt    = 0;
    done       = 1'b0;
    storing    = 1'b0;
    seen_wb    = 1'b0;
    last_instr = '0;
    #1;
    pc  = '0;
    idx = 0;
    for (int step = 0; step < 256 && exp_cnt < 64; step++) begin
      k = int'(pc >> 2);
      if (k >= PROG_LEN) break;
      d   = decoded_t'(prog[k][106:64]);
      res = prog[k][63:32];
      tar = prog[k][31:0];
      if (d.opcode == opc_jal && d.imm == '0) break;
      rc = d.opcode != opc_store && d.opcode != opc_branch && d.rd != '0;
      st = d.opcode == opc_store;
      cl = (d.opcode == opc_branch && res == '0) || d.opcode == opc_jalr;
      if (rc || st || cl) begin
        exp_kind[exp_cnt] = {rc, st, cl};
        exp_rd[exp_cnt]   = 32'(d.rd);
        exp_ren[exp_cnt]  = 32'(idx % IQ_DEPTH);
        exp_val[exp_cnt]  = res;
        exp_addr[exp_cnt] = tar;
        exp_len[exp_cnt]  = (d.func3[1:0] == 2'd2) ? 32'd3 : 32'(d.func3[1:0]);
        exp_cpc[exp_cnt]  = (d.opcode == opc_jalr) ? tar : pc + 32'd4;
        exp_cnt++;
      end
      if (d.opcode == opc_branch) begin
        pc = (res == '0) ? pc + 32'd4 : pc + d.imm;
      end else if (d.opcode == opc_jal) begin
        pc = pc + d.imm;
      end else if (d.opcode == opc_jalr) begin
        pc = tar;
      end else begin
        pc = pc + 32'd4;
      end
      idx = cl ? 0 : idx + 1;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      // decoder gets the word fetched one cycle earlier
      if (decode_req) begin
        check_field("decode_instr", last_instr, decode_instr);
      end
      if (fetch_valid) last_instr = fetch_instr;
      if (reg_commit_valid || store_valid || clear_valid) begin
        if (!seen_wb) begin
          $display("commit output pulsed before any writeback at %0t", $time);
          err_cnt++;
        end
        if (storing) begin
          $display("commit output pulsed while a store was pending at %0t", $time);
          err_cnt++;
        end
        if (seen_cnt >= exp_cnt) begin
          $display("commit output pulsed after the end of the expected trace at %0t", $time);
          err_cnt++;
        end else begin
          check_field("commit_kind", 32'(exp_kind[seen_cnt]),
                      32'({reg_commit_valid, store_valid, clear_valid}));
          if (reg_commit_valid) begin
            check_field("reg_commit.rd", exp_rd[seen_cnt], 32'(reg_commit.rd));
            check_field("reg_commit.rename", exp_ren[seen_cnt], 32'(reg_commit.rename));
            check_field("reg_commit.value", exp_val[seen_cnt], reg_commit.value);
          end
          if (store_valid) begin
            check_field("store.addr", exp_addr[seen_cnt], store.addr);
            check_field("store.data", exp_val[seen_cnt], store.data);
            check_field("store.len", exp_len[seen_cnt], 32'(store.len));
          end
          if (clear_valid) begin
            check_field("clear_pc", exp_cpc[seen_cnt], clear_pc);
          end
          seen_cnt++;
          if (seen_cnt == exp_cnt) done = 1'b1;
        end
      end
      if (store_valid) storing = 1'b1;
      if (store_done) storing = 1'b0;
      if (wb_valid) seen_wb = 1'b1;
    end
  end

endmodule

// ==== design/instr_queue.sv ====
module instr_queue #(
  parameter int IQ_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  output logic                        fetch_req,
  input  logic                        fetch_valid,
  input  iq_pkg::word_t               fetch_instr,
  input  iq_pkg::addr_t               fetch_pc,
  output logic                        decode_req,
  output iq_pkg::word_t               decode_instr,
  input  logic                        decode_valid,
  input  iq_pkg::decoded_t            decoded,
  output logic                        pc_write,
  output iq_pkg::addr_t               pc_write_val,
  input  logic                        wb_valid,
  input  logic [$clog2(IQ_DEPTH)-1:0] wb_idx,
  input  iq_pkg::word_t               wb_result,
  input  iq_pkg::addr_t               wb_tar_addr,
  output logic                        reg_commit_valid,
  output iq_pkg::reg_commit_t         reg_commit,
  output logic                        store_valid,
  output iq_pkg::store_req_t          store,
  input  logic                        store_done,
  output logic                        clear_valid,
  output iq_pkg::addr_t               clear_pc
);
  import iq_pkg::*;

  logic       alloc_valid;
  entry_t     alloc_entry;
  logic       full;
  logic       head_valid;
  entry_t     head_entry;
  logic [7:0] head_idx;
  logic       pop;
  logic       flush;

  fetch_sequencer #(
    .IQ_DEPTH(IQ_DEPTH)
  ) u_fetch_sequencer (
    .clk          (clk),
    .rst          (rst),
    .fetch_valid  (fetch_valid),
    .fetch_instr  (fetch_instr),
    .fetch_pc     (fetch_pc),
    .decode_valid (decode_valid),
    .decoded      (decoded),
    .full         (full),
    .flush        (flush),
    .fetch_req    (fetch_req),
    .decode_req   (decode_req),
    .decode_instr (decode_instr),
    .pc_write     (pc_write),
    .pc_write_val (pc_write_val),
    .alloc_valid  (alloc_valid),
    .alloc_entry  (alloc_entry)
  );

  iq_storage #(
    .IQ_DEPTH(IQ_DEPTH)
  ) u_iq_storage (
    .clk         (clk),
    .rst         (rst),
    .alloc_valid (alloc_valid),
    .alloc_entry (alloc_entry),
    .wb_valid    (wb_valid),
    .wb_idx      (wb_idx),
    .wb_result   (wb_result),
    .wb_tar_addr (wb_tar_addr),
    .pop         (pop),
    .flush       (flush),
    .full        (full),
    .head_valid  (head_valid),
    .head_entry  (head_entry),
    .head_idx    (head_idx)
  );

  commit_unit u_commit_unit (
    .clk              (clk),
    .rst              (rst),
    .head_valid       (head_valid),
    .head_entry       (head_entry),
    .head_idx         (head_idx),
    .store_done       (store_done),
    .pop              (pop),
    .flush            (flush),
    .reg_commit_valid (reg_commit_valid),
    .reg_commit       (reg_commit),
    .store_valid      (store_valid),
    .store            (store),
    .clear_valid      (clear_valid),
    .clear_pc         (clear_pc)
  );

endmodule

// ==== design/commit_unit.sv ====
module commit_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                head_valid,
  input  iq_pkg::entry_t      head_entry,
  input  logic [7:0]          head_idx,
  input  logic                store_done,
  output logic                pop,
  output logic                flush,
  output logic                reg_commit_valid,
  output iq_pkg::reg_commit_t reg_commit,
  output logic                store_valid,
  output iq_pkg::store_req_t  store,
  output logic                clear_valid,
  output iq_pkg::addr_t       clear_pc
);
  import iq_pkg::*;

  commit_state_e state;
  logic          is_store;
  logic          is_branch;
  logic          is_jalr;
  logic          mispredict;
  logic          writes_rd;

  assign is_store   = head_entry.dec.opcode == opc_store;
  assign is_branch  = head_entry.dec.opcode == opc_branch;
  assign is_jalr    = head_entry.dec.opcode == opc_jalr;
  // predicted taken, so a zero result means wrong path
  assign mispredict = is_branch && head_entry.result == '0;
  assign writes_rd  = !is_store && !is_branch && head_entry.dec.rd != '0;

  // nothing retires during the clear cycle
  assign pop = head_valid && head_entry.ready && state == commit_idle && !flush;

  assign clear_valid = flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= commit_idle;
      reg_commit_valid <= 1'b0;
      store_valid      <= 1'b0;
      flush            <= 1'b0;
    end else begin
      reg_commit_valid <= pop && writes_rd;
      store_valid      <= pop && is_store;
      flush            <= pop && (mispredict || is_jalr);
      if (pop && is_store) begin
        state <= commit_storing;
      end else if (state == commit_storing && store_done) begin
        state <= commit_idle;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      reg_commit.rd     <= head_entry.dec.rd;
      reg_commit.rename <= head_idx;
      reg_commit.value  <= head_entry.result;
      store.addr        <= head_entry.tar_addr;
      store.data        <= head_entry.result;
      // sw has func3 2, memory wants len 3
      if (head_entry.dec.func3[1:0] == 2'd2) begin
        store.len <= 2'd3;
      end else begin
        store.len <= head_entry.dec.func3[1:0];
      end
      clear_pc <= is_jalr ? head_entry.tar_addr : head_entry.pc + 32'd4;
    end
  end

  // one store in flight at a time
  a_store_from_idle: assert property (@(posedge clk) disable iff (rst)
    store_valid |-> $past(state) == commit_idle);

  a_done_while_storing: assert property (@(posedge clk) disable iff (rst)
    store_done |-> state == commit_storing);

endmodule

// ==== design/iq_storage.sv ====
module iq_storage #(
  parameter int IQ_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        alloc_valid,
  input  iq_pkg::entry_t              alloc_entry,
  input  logic                        wb_valid,
  input  logic [$clog2(IQ_DEPTH)-1:0] wb_idx,
  input  iq_pkg::word_t               wb_result,
  input  iq_pkg::addr_t               wb_tar_addr,
  input  logic                        pop,
  input  logic                        flush,
  output logic                        full,
  output logic                        head_valid,
  output iq_pkg::entry_t              head_entry,
  output logic [7:0]                  head_idx
);
  import iq_pkg::*;

  localparam int IDX_W = $clog2(IQ_DEPTH);

  entry_t           entries [IQ_DEPTH];
  logic [IDX_W-1:0] head;
  logic [IDX_W-1:0] tail;
  logic [IDX_W-1:0] count;

  // one slot stays free, so count never wraps
  assign count      = tail - head;
  assign full       = (32'(count) + 32'd1) >= 32'(IQ_DEPTH);
  assign head_valid = count != '0;
  assign head_entry = entries[head];
  assign head_idx   = 8'(head);

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
    end else if (flush) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (alloc_valid) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_valid) begin
      entries[tail] <= alloc_entry;
    end
    if (wb_valid) begin
      entries[wb_idx].result   <= wb_result;
      entries[wb_idx].tar_addr <= wb_tar_addr;
      entries[wb_idx].ready    <= 1'b1;
    end
  end

  // sequencer saw the queue not full when it started this fetch
  a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
    alloc_valid |-> !full);

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    pop |-> head_valid);

endmodule

// ==== design/fetch_sequencer.sv ====
module fetch_sequencer #(
  parameter int IQ_DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             fetch_valid,
  input  iq_pkg::word_t    fetch_instr,
  input  iq_pkg::addr_t    fetch_pc,
  input  logic             decode_valid,
  input  iq_pkg::decoded_t decoded,
  input  logic             full,
  input  logic             flush,
  output logic             fetch_req,
  output logic             decode_req,
  output iq_pkg::word_t    decode_instr,
  output logic             pc_write,
  output iq_pkg::addr_t    pc_write_val,
  output logic             alloc_valid,
  output iq_pkg::entry_t   alloc_entry
);
  import iq_pkg::*;

  fetch_state_e state;
  addr_t        pc_q;
  addr_t        next_pc;

  // pointers wrap on overflow and rename is 8 bits wide
  initial begin
    assert ((IQ_DEPTH & (IQ_DEPTH - 1)) == 0 && IQ_DEPTH >= 2 && IQ_DEPTH <= 256)
      else $fatal(1, "IQ_DEPTH must be a power of two between 2 and 256");
  end

  // static prediction: branches taken
  always_comb begin
    if (decoded.opcode == opc_jal || decoded.opcode == opc_branch) begin
      next_pc = pc_q + decoded.imm;
    end else begin
      next_pc = pc_q + 32'd4;
    end
  end

  assign alloc_valid = (state == fetch_decoding) && decode_valid && !flush;
  assign alloc_entry = '{dec: decoded, pc: pc_q, result: '0, tar_addr: '0, ready: 1'b0};

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= fetch_idle;
      fetch_req  <= 1'b0;
      decode_req <= 1'b0;
      pc_write   <= 1'b0;
    end else begin
      fetch_req  <= 1'b0;
      decode_req <= 1'b0;
      pc_write   <= 1'b0;
      if (flush) begin
        // drop whatever request is outstanding
        state <= fetch_idle;
      end else begin
        case (state)
          fetch_idle: begin
            if (!full) begin
              fetch_req <= 1'b1;
              state     <= fetch_fetching;
            end
          end
          fetch_fetching: begin
            if (fetch_valid) begin
              decode_req <= 1'b1;
              state      <= fetch_decoding;
            end
          end
          fetch_decoding: begin
            if (decode_valid) begin
              pc_write <= 1'b1;
              state    <= fetch_idle;
            end
          end
          default: state <= fetch_idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == fetch_fetching && fetch_valid) begin
      decode_instr <= fetch_instr;
      pc_q         <= fetch_pc;
    end
    if (alloc_valid) begin
      pc_write_val <= next_pc;
    end
  end

  // decoder answers only the request in flight
  a_decode_in_state: assert property (@(posedge clk) disable iff (rst)
    decode_valid |-> state == fetch_decoding);

endmodule

// ==== design/iq_pkg.sv ====
package iq_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  func3_t;

  // op covers every ALU and load instruction
  typedef enum logic [2:0] {
    opc_op     = 3'd0,
    opc_store  = 3'd1,
    opc_branch = 3'd2,
    opc_jal    = 3'd3,
    opc_jalr   = 3'd4
  } opcode_e;

  typedef enum logic [1:0] {
    fetch_idle     = 2'd0,
    fetch_fetching = 2'd1,
    fetch_decoding = 2'd2
  } fetch_state_e;

  typedef enum logic {
    commit_idle    = 1'b0,
    commit_storing = 1'b1
  } commit_state_e;

  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rd;
    func3_t   func3;
    word_t    imm;
  } decoded_t;

  typedef struct packed {
    decoded_t dec;
    addr_t    pc;
    word_t    result;
    addr_t    tar_addr;
    logic     ready;
  } entry_t;

  // len: 0 byte, 1 half, 3 word
  typedef struct packed {
    addr_t      addr;
    word_t      data;
    logic [1:0] len;
  } store_req_t;

  // rename is the queue index, wide enough for 256 entries
  typedef struct packed {
    reg_idx_t   rd;
    logic [7:0] rename;
    word_t      value;
  } reg_commit_t;

endpackage
